/* common/uart_pkg.sv */
/*
 * Shared constants for the UART command link
 * Frame timing, command opcodes and reply bytes
 */

package uart_pkg;

    // Serial timing, kept short for simulation
    localparam int CLKS_PER_BIT = 16;           // Clock cycles per serial bit
    localparam int HALF_BIT     = CLKS_PER_BIT / 2; // Start bit check point
    localparam int CNT_W        = $clog2(CLKS_PER_BIT); // Bit timer width

    // Frame layout
    localparam int DATA_BITS  = 8;              // Payload bits, LSB first
    localparam int FRAME_BITS = 11;             // Start + data + parity + stop
    localparam int FBIT_W     = $clog2(FRAME_BITS);

    // Command opcodes in the upper nibble
    localparam logic [3:0] OP_ON  = 4'h6;       // Set LED bits
    localparam logic [3:0] OP_OFF = 4'hD;       // Clear LED bits
    localparam logic [3:0] OP_TOG = 4'h9;       // Toggle LED bits

    // Reply bytes
    localparam logic [7:0] REPLY_ACK = 8'h3C;
    localparam logic [7:0] REPLY_NAK = 8'hC3;

    // LED register
    localparam int LED_W = 3;

endpackage

/* common/uart_byte_if.sv */
/*
 * Byte stream with valid/ready handshake
 * perr travels with the byte from the receiver
 */

`timescale 1ns/1ps

interface uart_byte_if;

    logic [7:0] data;   // Payload byte
    logic       valid;  // Source has a byte
    logic       ready;  // Sink can take it
    logic       perr;   // Parity error for this byte

    // Producer side
    modport src (
        output data,
        output valid,
        output perr,
        input  ready
    );

    // Consumer side
    modport dst (
        input  data,
        input  valid,
        input  perr,
        output ready
    );

endinterface

/* hw/uart/uart_rx.sv */
/*
 * UART receiver, 8 data bits, even parity, one stop bit
 * Samples mid-bit and keeps one received byte for the consumer
 */

`timescale 1ns/1ps

module uart_rx import uart_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   rx,
    uart_byte_if.src out
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_PARITY,
        S_STOP
    } state_t;

    state_t                 state;
    logic                   rx_meta;        // First synchronizer stage
    logic                   rx_sync;        // Safe to use in FSM
    logic [CNT_W-1:0]       cnt;            // Cycles within current bit
    logic [2:0]             bit_idx;        // Data bit being received
    logic [DATA_BITS-1:0]   shift_reg;      // Assembles LSB first
    logic                   par_bit;        // Received parity bit
    logic                   bit_end;        // Mid-bit sample point
    logic                   frame_done;     // Stop bit sampled
    logic                   load;           // Frame goes to holding reg

    assign bit_end    = (cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign frame_done = (state == S_STOP) && bit_end;
    // Drop the frame if the holding reg is full and not draining
    assign load       = frame_done && (!out.valid || out.ready);

    // Two-flop synchronizer, idles high like the line
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= S_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    if (!rx_sync) state <= S_START;     // Falling start edge
                end
                S_START: begin
                    if (cnt == CNT_W'(HALF_BIT - 1)) begin
                        cnt <= '0;
                        // Glitch rejection, start must still be low
                        state <= rx_sync ? S_IDLE : S_DATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_DATA: begin
                    if (bit_end) begin
                        cnt       <= '0;
                        shift_reg <= {rx_sync, shift_reg[DATA_BITS-1:1]};
                        bit_idx   <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= S_PARITY;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_PARITY: begin
                    if (bit_end) begin
                        cnt     <= '0;
                        par_bit <= rx_sync;
                        state   <= S_STOP;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_STOP: begin
                    if (bit_end) begin
                        cnt   <= '0;
                        state <= S_IDLE;            // Stop level not checked
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Holding register towards the responder
    always_ff @(posedge clk) begin
        if (rst) begin
            out.valid <= 1'b0;
        end else if (load) begin
            out.valid <= 1'b1;
        end else if (out.ready) begin
            out.valid <= 1'b0;                      // Byte taken
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out.data <= shift_reg;
            out.perr <= ^{shift_reg, par_bit};      // Even parity fails if odd
        end
    end

endmodule

/* hw/uart/uart_tx.sv */
/*
 * UART transmitter, frames a byte with even parity
 * One byte in flight, ready only while idle
 */

`timescale 1ns/1ps

module uart_tx import uart_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    uart_byte_if.dst in,
    output logic   tx
);

    logic                   busy;           // Frame on the line
    logic [CNT_W-1:0]       cnt;            // Cycles within current bit
    logic [FBIT_W-1:0]      bit_cnt;        // Bit now on the line
    logic [FRAME_BITS-2:0]  shift_reg;      // Bits after the start bit
    logic                   take;           // Handshake completes
    logic                   bit_end;

    assign in.ready = !busy;
    assign take     = in.valid && in.ready;
    assign bit_end  = (cnt == CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            tx      <= 1'b1;                    // Line idles high
            cnt     <= '0;
            bit_cnt <= '0;
        end else if (take) begin
            busy    <= 1'b1;
            tx      <= 1'b0;                    // Start bit next cycle
            cnt     <= '0;
            bit_cnt <= '0;
        end else if (busy) begin
            if (bit_end) begin
                cnt <= '0;
                if (bit_cnt == FBIT_W'(FRAME_BITS - 1)) begin
                    busy <= 1'b0;               // Stop bit done
                    tx   <= 1'b1;
                end else begin
                    tx      <= shift_reg[0];
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // Stop, parity, data; start bit goes straight to tx
    always_ff @(posedge clk) begin
        if (take) begin
            shift_reg <= {1'b1, ^in.data, in.data};
        end else if (busy && bit_end) begin
            shift_reg <= {1'b1, shift_reg[FRAME_BITS-2:1]};
        end
    end

    // in.perr has no meaning on the reply path

endmodule

/* hw/cmd_responder.sv */
/*
 * Command decoder and LED register
 * Answers each byte with ACK or NAK through the transmitter
 */

`timescale 1ns/1ps

module cmd_responder import uart_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    uart_byte_if.dst        cmd,
    uart_byte_if.src        reply,
    output logic [LED_W-1:0] led
);

    logic [3:0]        opcode;
    logic [LED_W-1:0]  mask;
    logic              op_known;        // Upper nibble is a command
    logic              cmd_ok;          // Byte will be ACKed
    logic              accept;          // Byte taken this cycle
    logic [LED_W-1:0]  led_next;

    assign opcode = cmd.data[7:4];
    assign mask   = cmd.data[LED_W-1:0];

    // One reply slot, stall the receiver while it is full
    assign cmd.ready = !reply.valid;
    assign accept    = cmd.valid && cmd.ready;

    always_comb begin
        op_known = 1'b0;
        led_next = led;
        case (opcode)
            OP_ON: begin
                op_known = 1'b1;
                led_next = led | mask;
            end
            OP_OFF: begin
                op_known = 1'b1;
                led_next = led & ~mask;
            end
            OP_TOG: begin
                op_known = 1'b1;
                led_next = led ^ mask;
            end
            default: op_known = 1'b0;
        endcase
    end

    // Bit 3 reserved, must be zero
    assign cmd_ok = op_known && !cmd.data[3] && !cmd.perr;

    always_ff @(posedge clk) begin
        if (rst) begin
            led         <= '0;
            reply.valid <= 1'b0;
        end else if (accept) begin
            if (cmd_ok) led <= led_next;    // Rejected byte leaves LEDs alone
            reply.valid <= 1'b1;
        end else if (reply.ready) begin
            reply.valid <= 1'b0;            // Transmitter took the reply
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            reply.data <= cmd_ok ? REPLY_ACK : REPLY_NAK;
        end
    end

    assign reply.perr = 1'b0;

endmodule

/* hw/uart_cmd_top.sv */
/*
 * UART command link top level
 * Receiver, responder and transmitter on plain board ports
 */

`timescale 1ns/1ps

module uart_cmd_top import uart_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             rx,        // Serial in
    output logic             tx,        // Serial out, idle high
    output logic [LED_W-1:0] led
);

    uart_byte_if rx_bus ();             // Receiver to responder
    uart_byte_if tx_bus ();             // Responder to transmitter

    uart_rx u_rx (
        .clk (clk),
        .rst (rst),
        .rx  (rx),
        .out (rx_bus.src)
    );

    cmd_responder u_resp (
        .clk   (clk),
        .rst   (rst),
        .cmd   (rx_bus.dst),
        .reply (tx_bus.src),
        .led   (led)
    );

    uart_tx u_tx (
        .clk (clk),
        .rst (rst),
        .in  (tx_bus.dst),
        .tx  (tx)
    );

endmodule

/* dv/tb_uart_cmd.sv */
/*
 * Testbench for the UART command link
 * Plays a command trace on rx and checks replies on tx and the LED state
 */

`timescale 1ns/1ps

module tb_uart_cmd import uart_pkg::*; ();

    localparam int MAX_ENTRIES   = 64;
    localparam int MAX_BURST     = 8;
    localparam int START_TIMEOUT = 30 * CLKS_PER_BIT;   // Cycles to wait for a reply
    localparam logic [23:0] END_MARK = 24'hFFFFFF;      // Unused trace slots
    localparam logic [31:0] SEED = 32'hc6050c13;

    logic             clk;
    logic             rst;
    logic             rx;
    logic             tx;
    logic [LED_W-1:0] led;

    // Packed as cmd[23:16] flags[15:12] reply[11:4] led[3:0]
    logic [23:0] trace_mem [0:MAX_ENTRIES-1];
    int          n_entries;
    logic [31:0] lfsr;
    int          n_checks;
    int          n_errors;
    int          n_timeouts;

    uart_cmd_top u_dut (
        .clk (clk),
        .rst (rst),
        .rx  (rx),
        .tx  (tx),
        .led (led)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                 // 40 ns period
    end

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
        n_checks++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %0h expected %0h", $time, msg, got, exp);
            n_errors++;
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr_next(lfsr);             // One step per bit
            val  = (val << 1) | int'(lfsr[0]);
        end
    endtask

    // Starts and ends 2 ns after a rising edge
    task automatic drive_frame(input logic [7:0] data, input logic corrupt);
        logic [10:0] frame;
        frame = {1'b1, ^data ^ corrupt, data, 1'b0};    // Stop, parity, data, start
        for (int b = 0; b < 11; b++) begin
            rx = frame[b];
            repeat (CLKS_PER_BIT) @(posedge clk);
            #2;
        end
    endtask

    // Sample on falling edges since tx moves on rising ones
    task automatic read_reply(output logic [7:0] data, output logic par_ok,
                              output logic stop_ok, output logic [LED_W-1:0] led_now);
        logic [8:0] bits;                       // Data then parity
        logic       seen;
        int         waited;
        seen    = 1'b0;
        waited  = 0;
        bits    = '0;
        data    = '0;
        par_ok  = 1'b0;
        stop_ok = 1'b0;
        led_now = '0;
        while (!seen && waited < START_TIMEOUT) begin
            @(negedge clk);
            waited++;
            if (tx == 1'b0) begin
                seen    = 1'b1;
                led_now = led;                  // LED state for this reply's command
            end
        end
        if (!seen) begin
            $display("Timeout: no reply start bit on tx within %0d cycles", START_TIMEOUT);
            n_timeouts++;
        end else begin
            repeat (HALF_BIT - 1) @(negedge clk);   // Middle of the start bit
            check_eq(32'(tx), 32'd0, "reply start bit low at mid-bit");
            for (int b = 0; b < 9; b++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                bits[b] = tx;
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            stop_ok = tx;
            data    = bits[7:0];
            par_ok  = ~^bits;                   // Even parity over data and parity bit
        end
    endtask

    // Frames of one burst go out back to back while the replies are read
    task automatic play_burst(input int first, input int n);
        logic [23:0]      e;                    // Entry on rx
        logic [23:0]      want;                 // Entry being answered
        logic [7:0]       rb;
        logic             rp;
        logic             rs;
        logic [LED_W-1:0] rl;
        int               dk;
        int               mk;
        fork
            begin
                for (dk = 0; dk < n; dk++) begin
                    e = trace_mem[first + dk];
                    drive_frame(e[23:16], e[12]);
                end
            end
            begin
                for (mk = 0; mk < n; mk++) begin
                    read_reply(rb, rp, rs, rl);
                    want = trace_mem[first + mk];
                    check_eq(32'(rb), 32'(want[11:4]),
                             $sformatf("entry %0d reply byte", first + mk));
                    check_eq(32'(rp), 32'd1,
                             $sformatf("entry %0d reply parity", first + mk));
                    check_eq(32'(rs), 32'd1,
                             $sformatf("entry %0d reply stop bit", first + mk));
                    check_eq(32'(rl), 32'(want[LED_W-1:0]),
                             $sformatf("led after entry %0d", first + mk));
                end
            end
        join
        @(posedge clk);
        #2;                                     // Back on the drive grid
    endtask

    initial begin
        int i;
        int n;
        int gap;
        rst        = 1'b1;
        rx         = 1'b1;                      // Line idle
        lfsr       = SEED;
        n_checks   = 0;
        n_errors   = 0;
        n_timeouts = 0;
        n_entries  = 0;
        for (int k = 0; k < MAX_ENTRIES; k++) trace_mem[k] = END_MARK;
        $readmemh("dv/uart_cmd_trace.txt", trace_mem);
        while (n_entries < MAX_ENTRIES && trace_mem[n_entries] != END_MARK) n_entries++;
        check_eq(32'(n_entries > 0), 32'd1, "trace entries loaded");

        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        // Quiet line after reset
        for (int b = 0; b < 20; b++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            check_eq(32'(tx), 32'd1, "tx idle after reset");
            check_eq(32'(led), 32'd0, "led zero after reset");
        end
        @(posedge clk);
        #2;

        i = 0;
        while (i < n_entries) begin
            take_bits(4, gap);                  // 0 to 15 idle bit times
            repeat (gap * CLKS_PER_BIT) begin
                @(posedge clk);
                #2;
            end
            n = 1;
            // Flag bit 1 chains an entry to the one before it
            while (i + n < n_entries && trace_mem[i + n][13] && n < MAX_BURST) n++;
            play_burst(i, n);
            i += n;
        end

        $display("Checks: %0d  mismatches: %0d  timeouts: %0d", n_checks, n_errors, n_timeouts);
        if (n_errors == 0 && n_timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* dv/uart_cmd_trace.txt */
// Columns: cmd(2 hex) flags(1 hex) reply(2 hex) led(1 hex), packed as one word
// flags bit 0 corrupts parity, bit 1 sends right after the previous frame
6103C1
6603C7
D203C5
9303C6
6F0C36
450C36
911C36
D403C2
010C32
9703C5
980C35
6003C5
651C35
D703C0
6203C2
9423C6
6A2C36
D13C36
9603C0
9303C3
6103C3
FF0C33
D323C0
6703C7
9523C2
D203C0

/* tb.f */
common/uart_pkg.sv
common/uart_byte_if.sv
hw/uart/uart_rx.sv
hw/uart/uart_tx.sv
hw/cmd_responder.sv
hw/uart_cmd_top.sv
dv/tb_uart_cmd.sv

/* Makefile */
TOP = tb_uart_cmd

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f tb.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
